// File: hw/cmd_decode.sv
/*
 * byte stream parser, collects an opcode and its argument bytes and offers
 * the complete command to the executor; the stream stalls while it waits
 */
module cmd_decode import led_pkg::*; (
    input  logic    clk_root,
    input  logic    rst_n,
    input  byte_t   cmd_byte,
    input  logic    cmd_valid,
    output logic    cmd_ready,
    output opcode_t op_code,
    output col_t    op_x,
    output row_t    op_y,
    output byte_t   op_arg,
    output logic    op_valid,
    input  logic    op_ready
);

    decode_state_t state;
    logic          take;      // byte accepted this cycle
    logic          known_op;

    assign cmd_ready = (state != ISSUE);
    assign take      = cmd_valid && cmd_ready;
    assign known_op  = cmd_byte inside {OP_PIXEL, OP_FILL, OP_ENABLE};

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state    <= OPCODE;
            op_valid <= 1'b0;
        end else begin
            case (state)
                OPCODE: begin
                    if (take && known_op) begin
                        state <= ARG0;  // unknown bytes fall through here
                    end
                end
                ARG0: begin
                    if (take) begin
                        if (op_code == OP_PIXEL) begin
                            state <= ARG1;
                        end else begin
                            state    <= ISSUE;
                            op_valid <= 1'b1;
                        end
                    end
                end
                ARG1: begin
                    if (take) begin
                        state <= ARG2;
                    end
                end
                ARG2: begin
                    if (take) begin
                        state    <= ISSUE;
                        op_valid <= 1'b1;
                    end
                end
                ISSUE: begin
                    if (op_ready) begin
                        state    <= OPCODE;
                        op_valid <= 1'b0;
                    end
                end
                default: state <= OPCODE;
            endcase
        end
    end

    // command payload, loaded as bytes arrive
    always_ff @(posedge clk_root) begin
        if (take) begin
            case (state)
                OPCODE: if (known_op) op_code <= opcode_t'(cmd_byte);
                ARG0: begin
                    if (op_code == OP_PIXEL) begin
                        op_x <= cmd_byte[2:0];
                    end else begin
                        op_arg <= cmd_byte;  // fill colour or enable mask
                    end
                end
                ARG1: op_y <= cmd_byte[2:0];
                ARG2: op_arg <= cmd_byte;
                default: ;
            endcase
        end
    end

    a_valid_in_issue: assert property (@(posedge clk_root) disable iff (!rst_n)
        op_valid |-> state == ISSUE);

endmodule

// File: hw/fb_exec.sv
/*
 * command executor, turns pixel and fill commands into framebuffer writes
 * and keeps the colour enable mask used by the scan
 */
module fb_exec import led_pkg::*; (
    input  logic     clk_root,
    input  logic     rst_n,
    input  opcode_t  op_code,
    input  col_t     op_x,
    input  row_t     op_y,
    input  byte_t    op_arg,
    input  logic     op_valid,
    output logic     op_ready,
    output logic     wr_en,
    output fb_addr_t wr_addr,
    output logic     wr_top,
    output logic     wr_bot,
    output pixel_t   wr_pixel,
    output rgb_t     rgb_mask
);

    localparam fb_addr_t FILL_LAST = fb_addr_t'(HALF_ROWS * NUM_COLS - 1);

    logic      filling;
    fb_addr_t  fill_addr;
    pixel_t    fill_pixel;
    logic      accept;
    logic      pix_top;
    half_row_t pix_row;

    assign op_ready = !filling;
    assign accept   = op_valid && op_ready;

    // top half holds rows 0..3, bottom half rows 4..7
    assign pix_top = (op_y < row_t'(HALF_ROWS));
    assign pix_row = op_y[1:0];  // same row index within either half

    always_comb begin
        if (filling) begin
            wr_en    = 1'b1;
            wr_addr  = fill_addr;
            wr_top   = 1'b1;
            wr_bot   = 1'b1;
            wr_pixel = fill_pixel;
        end else begin
            wr_en    = op_valid && (op_code == OP_PIXEL);  // write on accept
            wr_addr  = {pix_row, op_x};
            wr_top   = pix_top;
            wr_bot   = !pix_top;
            wr_pixel = op_arg[5:0];
        end
    end

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            filling  <= 1'b0;
            rgb_mask <= 3'b111;
        end else begin
            if (filling) begin
                fill_addr <= fill_addr + 1'b1;
                if (fill_addr == FILL_LAST) filling <= 1'b0;
            end else if (accept && op_code == OP_FILL) begin
                filling    <= 1'b1;
                fill_addr  <= '0;
                fill_pixel <= op_arg[5:0];
            end
            if (accept && op_code == OP_ENABLE) rgb_mask <= op_arg[2:0];
        end
    end

    a_both_halves_fill: assert property (@(posedge clk_root) disable iff (!rst_n)
        (wr_top && wr_bot) |-> (filling && !op_ready));

endmodule

// File: hw/framebuffer.sv
/*
 * pixel memory, two halves sharing one word address; writes pick a half,
 * reads return both halves one cycle after the address
 */
module framebuffer import led_pkg::*; (
    input  logic             clk_root,
    input  logic             wr_en,
    input  fb_addr_t         wr_addr,
    input  logic             wr_top,
    input  logic             wr_bot,
    input  pixel_t           wr_pixel,
    input  fb_addr_t         rd_addr,
    output pixel_t [1:0]     rd_data     // [1] top, [0] bottom
);

    localparam int DEPTH = NUM_COLS * NUM_ROWS / 2;

    pixel_t mem_top [DEPTH];
    pixel_t mem_bot [DEPTH];

    always_ff @(posedge clk_root) begin
        if (wr_en && wr_top) begin
            mem_top[wr_addr] <= wr_pixel;
        end
        if (wr_en && wr_bot) begin
            mem_bot[wr_addr] <= wr_pixel;
        end
    end

    // registered read port for the scan
    always_ff @(posedge clk_root) begin
        rd_data <= {mem_top[rd_addr], mem_bot[rd_addr]};
    end

endmodule

// File: hw/led_matrix_top.sv
/*
 * LED matrix display path, byte commands in and panel shift signals out;
 * SHOW_BASE sets the lit time of the lowest brightness plane
 */
module led_matrix_top import led_pkg::*; #(
    parameter int SHOW_BASE = 4
) (
    input  logic      clk_root,
    input  logic      rst_n,
    input  byte_t     cmd_byte,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    output rgb_t      rgb_top,
    output rgb_t      rgb_bot,
    output logic      clk_pixel,
    output logic      row_latch,
    output logic      output_enable,
    output half_row_t row_addr
);

    // parsed command
    opcode_t      op_code;
    col_t         op_x;
    row_t         op_y;
    byte_t        op_arg;
    logic         op_valid;
    logic         op_ready;

    // memory ports
    logic         wr_en;
    fb_addr_t     wr_addr;
    logic         wr_top;
    logic         wr_bot;
    pixel_t       wr_pixel;
    fb_addr_t     rd_addr;
    pixel_t [1:0] rd_data;
    rgb_t         rgb_mask;

    cmd_decode u_cmd_decode (
        .clk_root  (clk_root),
        .rst_n     (rst_n),
        .cmd_byte  (cmd_byte),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .op_code   (op_code),
        .op_x      (op_x),
        .op_y      (op_y),
        .op_arg    (op_arg),
        .op_valid  (op_valid),
        .op_ready  (op_ready)
    );

    fb_exec u_fb_exec (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .op_code  (op_code),
        .op_x     (op_x),
        .op_y     (op_y),
        .op_arg   (op_arg),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_top   (wr_top),
        .wr_bot   (wr_bot),
        .wr_pixel (wr_pixel),
        .rgb_mask (rgb_mask)
    );

    framebuffer u_framebuffer (
        .clk_root (clk_root),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_top   (wr_top),
        .wr_bot   (wr_bot),
        .wr_pixel (wr_pixel),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    matrix_scan #(
        .SHOW_BASE (SHOW_BASE)
    ) u_matrix_scan (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .rd_data       (rd_data),
        .rgb_mask      (rgb_mask),
        .rd_addr       (rd_addr),
        .rgb_top       (rgb_top),
        .rgb_bot       (rgb_bot),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_addr      (row_addr)
    );

endmodule

// File: hw/led_pkg.sv
/*
 * shared geometry, data types, opcodes and state encodings for the LED
 * matrix display path, imported by every RTL module
 */
package led_pkg;

    localparam int NUM_COLS   = 8;
    localparam int NUM_ROWS   = 8;
    localparam int HALF_ROWS  = 4;  // rows per half, also scanned row addresses
    localparam int NUM_PLANES = 2;  // bits per colour channel

    typedef logic [7:0] byte_t;
    typedef logic [5:0] pixel_t;    // r[5:4] g[3:2] b[1:0]
    typedef logic [2:0] col_t;
    typedef logic [2:0] row_t;
    typedef logic [1:0] half_row_t;
    typedef logic [4:0] fb_addr_t;  // {half_row, col}
    typedef logic [2:0] rgb_t;      // {r, g, b}

    // command opcodes as they appear on the byte stream
    typedef enum logic [7:0] {
        OP_PIXEL  = 8'd1,  // x, y, colour
        OP_FILL   = 8'd2,  // colour
        OP_ENABLE = 8'd3   // mask {r, g, b}
    } opcode_t;

    typedef enum logic [2:0] {
        OPCODE,
        ARG0,
        ARG1,
        ARG2,
        ISSUE
    } decode_state_t;

    typedef enum logic [1:0] {
        FETCH,
        SHIFT,
        LATCH,
        SHOW
    } scan_state_t;

endpackage

// File: hw/matrix_scan.sv
/*
 * panel scan sequencer; per row and bit plane it shifts out one line,
 * latches it and lights it for a time weighted by the plane
 */
module matrix_scan import led_pkg::*; #(
    parameter int SHOW_BASE = 4
) (
    input  logic         clk_root,
    input  logic         rst_n,
    input  pixel_t [1:0] rd_data,
    input  rgb_t         rgb_mask,
    output fb_addr_t     rd_addr,
    output rgb_t         rgb_top,
    output rgb_t         rgb_bot,
    output logic         clk_pixel,
    output logic         row_latch,
    output logic         output_enable,
    output half_row_t    row_addr
);

    localparam int PLANE_W  = $clog2(NUM_PLANES);
    localparam int SHOW_MAX = SHOW_BASE << (NUM_PLANES - 1);
    localparam int CNT_W    = $clog2(SHOW_MAX + 1);

    scan_state_t          state;
    half_row_t            row;
    logic [PLANE_W-1:0]   plane;
    col_t                 col;
    logic                 phase;      // high in the clk_pixel cycle
    logic [CNT_W-1:0]     show_cnt;
    logic [CNT_W-1:0]     show_last;

    // pick bit p of each 2-bit channel
    function automatic rgb_t plane_bits(pixel_t px, logic [PLANE_W-1:0] p);
        plane_bits = {px[4 + p], px[2 + p], px[p]};
    endfunction

    assign show_last = CNT_W'((SHOW_BASE << plane) - 1);

    // next column is requested in the rising cycle so data is ready on fall
    assign rd_addr = {row, (state == SHIFT && phase) ? col_t'(col + 1'b1) : col};

    assign clk_pixel     = (state == SHIFT) && phase;
    assign row_latch     = (state == LATCH);
    assign output_enable = (state == SHOW);
    assign rgb_top = (state == SHIFT) ? plane_bits(rd_data[1], plane) & rgb_mask : '0;
    assign rgb_bot = (state == SHIFT) ? plane_bits(rd_data[0], plane) & rgb_mask : '0;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state    <= FETCH;
            row      <= '0;
            plane    <= '0;
            col      <= '0;
            phase    <= 1'b0;
            show_cnt <= '0;
            row_addr <= '0;
        end else begin
            case (state)
                FETCH: state <= SHIFT;  // word for column 0 in flight
                SHIFT: begin
                    phase <= !phase;
                    if (phase) begin
                        if (col == col_t'(NUM_COLS - 1)) begin
                            col      <= '0;
                            state    <= LATCH;
                            row_addr <= row;  // moves with the latch pulse
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                LATCH: begin
                    state    <= SHOW;
                    show_cnt <= '0;
                end
                SHOW: begin
                    show_cnt <= show_cnt + 1'b1;
                    if (show_cnt == show_last) begin
                        state <= FETCH;
                        if (plane == PLANE_W'(NUM_PLANES - 1)) begin
                            plane <= '0;
                            row   <= (row == half_row_t'(HALF_ROWS - 1)) ? '0 : row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    a_latch_dark: assert property (@(posedge clk_root) disable iff (!rst_n)
        !(row_latch && output_enable));

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_led_matrix \
    -f src.f -o sim_led_matrix \
    && ./obj_dir/sim_led_matrix | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

// File: src.f
hw/led_pkg.sv
hw/cmd_decode.sv
hw/fb_exec.sv
hw/framebuffer.sv
hw/matrix_scan.sv
hw/led_matrix_top.sv
tb/clk_gen.sv
tb/tb_led_matrix.sv

// File: tb/clk_gen.sv
/*
 * testbench clock and reset source, free running clk_root and a
 * synchronous active-low reset held for the first cycles
 */
module clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_root,
    output logic rst_n
);

    initial begin
        clk_root = 1'b0;
        forever #(PERIOD / 2) clk_root = ~clk_root;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_root);
        rst_n <= 1'b1;  // released on a rising edge
    end

endmodule

// File: tb/tb_led_matrix.sv
/*
 * testbench for the LED matrix display path; sends command bytes, keeps a
 * reference image and mask, and checks every shifted line of chosen frames
 */
module tb_led_matrix import led_pkg::*; ();

    localparam int SHOW_BASE    = 4;
    localparam int LINE_FIXED   = 2 + 2 * NUM_COLS;  // fetch, shift, latch
    localparam int FRAME_LEN    = HALF_ROWS * (NUM_PLANES * LINE_FIXED
                                  + SHOW_BASE * ((1 << NUM_PLANES) - 1));
    localparam int NUM_BYTES    = 2 + 24 + 4 + 10 + 14;  // bytes per test group
    localparam int CHECK_FRAMES = 6;
    localparam int TIMEOUT_CYCLES = (NUM_BYTES * 4 + CHECK_FRAMES * FRAME_LEN) * 2;

    logic      clk_root;
    logic      rst_n;
    byte_t     cmd_byte;
    logic      cmd_valid;
    logic      cmd_ready;
    rgb_t      rgb_top;
    rgb_t      rgb_bot;
    logic      clk_pixel;
    logic      row_latch;
    logic      output_enable;
    half_row_t row_addr;

    pixel_t      ref_img [NUM_ROWS][NUM_COLS];
    rgb_t        ref_mask;
    int unsigned lcg_state;
    int          mismatch_cnt;
    int          other_cnt;
    int          lines_checked;
    int          bytes_sent;
    int          cycle_cnt = 0;

    // panel capture state
    int          frames_left;
    int          frames_done;
    logic        in_frame;
    logic        seen_latch;
    int          latch_idx;
    int          shift_cnt;
    int          oe_cnt;      // lit cycles since the last latch
    half_row_t   last_row;
    rgb_t        cap_top [NUM_COLS];
    rgb_t        cap_bot [NUM_COLS];

    clk_gen #(.PERIOD(20), .RESET_CYCLES(8)) u_clk_gen (
        .clk_root (clk_root),
        .rst_n    (rst_n)
    );

    led_matrix_top #(
        .SHOW_BASE (SHOW_BASE)
    ) u_led_matrix_top (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .cmd_byte      (cmd_byte),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .rgb_top       (rgb_top),
        .rgb_bot       (rgb_bot),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_addr      (row_addr)
    );

    function automatic byte_t rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // panel bits for one pixel of the reference image
    function automatic rgb_t expected_rgb(int row, int col, int plane);
        pixel_t     px;
        logic [1:0] red;
        logic [1:0] green;
        logic [1:0] blue;
        px    = ref_img[row][col];
        red   = px[5:4];
        green = px[3:2];
        blue  = px[1:0];
        return {red[plane], green[plane], blue[plane]} & ref_mask;
    endfunction

    // called just after a rising edge, returns after the accepting edge
    task automatic send_byte(input byte_t b);
        cmd_byte  <= b;
        cmd_valid <= 1'b1;
        @(negedge clk_root);
        while (!cmd_ready) @(negedge clk_root);
        @(posedge clk_root);
        bytes_sent++;
    endtask

    task automatic send_pixel(input byte_t x, input byte_t y, input byte_t colour);
        send_byte(OP_PIXEL);
        send_byte(x);
        send_byte(y);
        send_byte(colour);
        ref_img[y[2:0]][x[2:0]] = colour[5:0];
    endtask

    task automatic send_fill(input byte_t colour);
        int r;
        int c;
        send_byte(OP_FILL);
        send_byte(colour);
        for (r = 0; r < NUM_ROWS; r++) begin
            for (c = 0; c < NUM_COLS; c++) ref_img[r][c] = colour[5:0];
        end
    endtask

    task automatic send_enable(input byte_t mask);
        send_byte(OP_ENABLE);
        send_byte(mask);
        ref_mask = mask[2:0];
    endtask

    // idle the stream, let a fill finish, then check whole frames
    task automatic check_frames(input int n);
        cmd_valid <= 1'b0;
        repeat (40) @(posedge clk_root);
        frames_left = n;
        while (frames_left > 0) @(posedge clk_root);
    endtask

    // lit time of the line shown before this latch
    task automatic check_show_len(input int plane);
        int exp_len;
        exp_len = SHOW_BASE * (2 ** plane);
        if (oe_cnt != exp_len) begin
            $display("MISMATCH t=%0t output_enable cycles plane %0d expected %0d got %0d",
                     $time, plane, exp_len, oe_cnt);
            mismatch_cnt++;
        end
    endtask

    task automatic check_line(input int exp_row, input int plane);
        rgb_t exp_top;
        rgb_t exp_bot;
        int   c;
        lines_checked++;
        if (row_addr != half_row_t'(exp_row)) begin
            $display("MISMATCH t=%0t row_addr expected %0d got %0d", $time, exp_row, row_addr);
            mismatch_cnt++;
        end
        if (shift_cnt != NUM_COLS) begin
            $display("error at %0t: %0d clk_pixel pulses before the latch instead of %0d",
                     $time, shift_cnt, NUM_COLS);
            other_cnt++;
        end
        for (c = 0; c < NUM_COLS; c++) begin
            exp_top = expected_rgb(exp_row, c, plane);
            exp_bot = expected_rgb(exp_row + HALF_ROWS, c, plane);
            if (cap_top[c] !== exp_top) begin
                $display("MISMATCH t=%0t rgb_top row %0d col %0d plane %0d expected %b got %b",
                         $time, exp_row, c, plane, exp_top, cap_top[c]);
                mismatch_cnt++;
            end
            if (cap_bot[c] !== exp_bot) begin
                $display("MISMATCH t=%0t rgb_bot row %0d col %0d plane %0d expected %b got %b",
                         $time, exp_row, c, plane, exp_bot, cap_bot[c]);
                mismatch_cnt++;
            end
        end
    endtask

    // panel capture, sampled mid-cycle
    always @(negedge clk_root) begin
        if (rst_n) begin
            if (clk_pixel) begin
                if (shift_cnt < NUM_COLS) begin
                    cap_top[shift_cnt] = rgb_top;
                    cap_bot[shift_cnt] = rgb_bot;
                end
                shift_cnt = shift_cnt + 1;
            end
            if (output_enable) oe_cnt = oe_cnt + 1;
            if (row_latch) begin
                // a frame opens on row 0 right after row 3
                if (frames_left > 0 && !in_frame && seen_latch && row_addr == 2'd0
                        && last_row == half_row_t'(HALF_ROWS - 1)) begin
                    in_frame  = 1'b1;
                    latch_idx = 0;
                end
                if (in_frame) begin
                    if (latch_idx > 0) check_show_len((latch_idx - 1) % NUM_PLANES);
                    check_line(latch_idx / NUM_PLANES, latch_idx % NUM_PLANES);
                    latch_idx = latch_idx + 1;
                    if (latch_idx == HALF_ROWS * NUM_PLANES) begin
                        in_frame    = 1'b0;
                        frames_left = frames_left - 1;
                        frames_done = frames_done + 1;
                    end
                end
                seen_latch = (frames_left > 0);
                last_row   = row_addr;
                shift_cnt  = 0;
                oe_cnt     = 0;
            end
        end
    end

    always @(posedge clk_root) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles: %0d bytes sent, %0d frames checked, %0d errors",
                     cycle_cnt, bytes_sent, frames_done, mismatch_cnt + other_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        byte_t mask;
        cmd_byte      = '0;
        cmd_valid     = 1'b0;
        lcg_state     = 16;
        ref_mask      = 3'b111;  // reset value of the colour enable
        mismatch_cnt  = 0;
        other_cnt     = 0;
        lines_checked = 0;
        bytes_sent    = 0;
        frames_left   = 0;
        frames_done   = 0;
        in_frame      = 1'b0;
        seen_latch    = 1'b0;
        latch_idx     = 0;
        shift_cnt     = 0;
        oe_cnt        = 0;
        last_row      = '0;
        @(posedge clk_root);
        while (!rst_n) @(posedge clk_root);

        send_fill(rand_byte());
        check_frames(1);

        repeat (6) send_pixel(rand_byte(), rand_byte(), rand_byte());
        check_frames(1);

        mask = rand_byte();
        if (mask[2:0] == 3'b111) mask[2:0] = 3'b010;  // keep one channel off
        send_enable(mask);
        check_frames(1);
        send_enable(8'h07);
        check_frames(1);

        // stray opcodes around pixel commands
        send_byte(8'h5a);
        send_pixel(8'd0, 8'd7, rand_byte());
        send_byte(8'h00);
        send_pixel(8'd7, 8'd0, rand_byte());
        check_frames(1);

        // these pixels stall behind the fill
        send_fill(rand_byte());
        send_pixel(8'd3, 8'd3, rand_byte());
        send_pixel(8'd4, 8'd4, rand_byte());
        send_pixel(rand_byte(), rand_byte(), rand_byte());
        check_frames(1);

        if (frames_done != CHECK_FRAMES) begin
            $display("error: %0d of %0d frames were checked", frames_done, CHECK_FRAMES);
            other_cnt++;
        end
        $display("checked %0d lines in %0d frames: %0d mismatches, %0d other errors",
                 lines_checked, frames_done, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
